//--- filelist.f
+incdir+logic
logic/hsalign_pkg.sv
logic/hsalign_bus_port.sv
logic/hsalign_ctrl_regs.sv
logic/hsalign_biterr_counter.sv
logic/hsalign_align_engine.sv
logic/hsalign_top.sv
sim/hsalign_sva.sv
sim/hsalign_tb.sv

//--- logic/hsalign_align_engine.sv
`timescale 1ns/1ps
`include "hsalign_settings.svh"

module hsalign_align_engine import hsalign_pkg::*; (
    input  logic                     sysclk_i,
    input  logic                     wb_rst_i,
    input  bus_req_t                 req_i,
    input  logic                     task_i,
    input  logic                     commit_i,
    input  logic                     cout_biterr_i,
    input  logic                     dout_biterr_i,
    output logic                     idelay_cout_load_o,
    output logic                     idelay_dout_load_o,
    output logic [`HSA_IDELAY_W-1:0] idelay_value_o,
    output logic                     iserdes_cout_bitslip_o,
    output logic                     iserdes_dout_bitslip_o,
    output logic                     cout_capture_o,
    output logic                     dout_capture_o,
    output logic                     cout_captured_o,
    output count_t                   count_o
);

    logic task_q;
    logic use_dout_q;
    logic err_q;
    logic interval_load;

    // strobes straight off the task cycle
    assign idelay_cout_load_o     = task_i && req_i.we && req_i.adr == REG_COUT_IDELAY;
    assign idelay_dout_load_o     = task_i && req_i.we && req_i.adr == REG_DOUT_IDELAY;
    assign iserdes_cout_bitslip_o = task_i && req_i.we && req_i.adr == REG_COUT_DATA;
    assign iserdes_dout_bitslip_o = task_i && req_i.we && req_i.adr == REG_DOUT_DATA;
    assign cout_capture_o         = task_i && !req_i.we && req_i.adr == REG_COUT_DATA;
    assign dout_capture_o         = task_i && !req_i.we && req_i.adr == REG_DOUT_DATA;
    // one shared tap value for both channels
    assign idelay_value_o         = req_i.dat[`HSA_IDELAY_W-1:0];

    // interval write to either count register
    assign interval_load = task_i && req_i.we &&
                           (req_i.adr == REG_COUT_COUNT || req_i.adr == REG_DOUT_COUNT);

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            task_q     <= 1'b0;
            use_dout_q <= 1'b0;
        end else begin
            task_q <= task_i;
            // the interval write also picks the channel
            if (interval_load) use_dout_q <= (req_i.adr == REG_DOUT_COUNT);
        end
    end

    // registered error of the selected channel
    always_ff @(posedge sysclk_i) begin
        err_q <= use_dout_q ? dout_biterr_i : cout_biterr_i;
    end

    // ack of a task access
    assign cout_captured_o = commit_i && task_q;

    hsalign_biterr_counter u_biterr_counter (
        .sysclk_i   (sysclk_i),
        .wb_rst_i   (wb_rst_i),
        .err_i      (err_q),
        .interval_i (req_i.dat[`HSA_INTERVAL_W-1:0]),
        .load_i     (interval_load),
        .count_o    (count_o)
    );

endmodule

//--- logic/hsalign_biterr_counter.sv
`timescale 1ns/1ps

module hsalign_biterr_counter import hsalign_pkg::*; (
    input  logic      sysclk_i,
    input  logic      wb_rst_i,
    input  logic      err_i,
    input  interval_t interval_i,
    input  logic      load_i,
    output count_t    count_o
);

    interval_t interval_q;
    interval_t timer_q;
    count_t    run_q;
    count_t    count_q;
    logic      window_end;

    // last cycle of the current window
    assign window_end = (timer_q == interval_q - interval_t'(1));

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            interval_q <= '0;
            timer_q    <= '0;
            run_q      <= '0;
            count_q    <= '0;
        end else if (load_i) begin
            // fresh window with the new length
            interval_q <= interval_i;
            timer_q    <= '0;
            run_q      <= '0;
        end else if (interval_q != '0) begin
            if (window_end) begin
                // publish and restart
                count_q <= run_q + count_t'(err_i);
                run_q   <= '0;
                timer_q <= '0;
            end else begin
                run_q   <= run_q + count_t'(err_i);
                timer_q <= timer_q + interval_t'(1);
            end
        end
    end

    assign count_o = count_q;

endmodule

//--- logic/hsalign_bus_port.sv
`timescale 1ns/1ps
`include "hsalign_settings.svh"

module hsalign_bus_port import hsalign_pkg::*; (
    input  logic                    sysclk_i,
    input  logic                    wb_rst_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [`HSA_ADR_W-1:0]   wb_adr_i,
    input  logic [`HSA_SEL_W-1:0]   wb_sel_i,
    input  logic [`HSA_DAT_W-1:0]   wb_dat_i,
    input  ctrl_state_t             ctrl_i,
    input  logic [`HSA_IDELAY_W-1:0] idelay_cout_current_i,
    input  logic [`HSA_IDELAY_W-1:0] idelay_dout_current_i,
    input  logic [31:0]             cout_data_i,
    input  logic [7:0]              dout_data_i,
    input  count_t                  count_i,
    output logic                    wb_ack_o,
    output logic [`HSA_DAT_W-1:0]   wb_dat_o,
    output bus_req_t                req_o,
    output logic                    task_o,
    output logic                    commit_o
);

    bus_state_e state_q;
    bus_req_t   req_q;
    word_t      dat_q;
    logic       accept;

    // counter, data and IDELAY-write accesses need the extra task cycle
    function automatic logic is_task_access(logic [`HSA_ADR_W-1:0] adr, logic we);
        case (adr)
            REG_COUT_COUNT, REG_DOUT_COUNT,
            REG_COUT_DATA, REG_DOUT_DATA: return 1'b1;
            REG_COUT_IDELAY, REG_DOUT_IDELAY: return we;
            default: return 1'b0;
        endcase
    endfunction

    // control readback, channel specific bits spliced over the shared ones
    function automatic word_t ctrl_word(ctrl_state_t c, logic dout_sel);
        word_t w;
        w = '0;
        w[2] = c.iserdes_rst;
        w[4] = c.oserdes_rst;
        w[7] = dout_sel & c.dout_phase;
        w[8] = dout_sel ? c.dout_en : c.cout_en;
        w[9] = w[8];
        w[10] = c.cin_train;
        return w;
    endfunction

    assign accept = (state_q == IDLE) && wb_cyc_i && wb_stb_i;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////
    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (accept) state_q <= is_task_access(wb_adr_i, wb_we_i) ? TASK : ACK;
                TASK: state_q <= ACK;
                default: state_q <= IDLE;
            endcase
        end
    end

    // hold the request, write data merged byte by byte
    always_ff @(posedge sysclk_i) begin
        if (accept) begin
            req_q.adr <= wb_adr_i;
            req_q.we  <= wb_we_i;
            req_q.sel <= wb_sel_i;
            for (int b = 0; b < `HSA_SEL_W; b++) begin
                if (wb_sel_i[b]) req_q.dat[8*b +: 8] <= wb_dat_i[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // read data
    ////////////////////////////////////////
    always_ff @(posedge sysclk_i) begin
        if (accept && !wb_we_i) begin
            // static values are taken right at acceptance
            case (wb_adr_i)
                REG_COUT_CTRL:   dat_q <= ctrl_word(ctrl_i, 1'b0);
                REG_DOUT_CTRL:   dat_q <= ctrl_word(ctrl_i, 1'b1);
                REG_COUT_IDELAY: dat_q <= word_t'(idelay_cout_current_i);
                REG_DOUT_IDELAY: dat_q <= word_t'(idelay_dout_current_i);
                default:         dat_q <= '0;
            endcase
        end else if (state_q == TASK && !req_q.we) begin
            // counter and captured data come in during the task cycle
            case (req_q.adr)
                REG_COUT_COUNT, REG_DOUT_COUNT: dat_q <= word_t'(count_i);
                REG_COUT_DATA: dat_q <= word_t'(cout_data_i);
                REG_DOUT_DATA: dat_q <= word_t'(dout_data_i);
                default:       dat_q <= '0;
            endcase
        end
    end

    assign wb_ack_o = (state_q == ACK);
    assign wb_dat_o = dat_q;
    assign req_o    = req_q;
    assign task_o   = (state_q == TASK);
    assign commit_o = (state_q == ACK);

endmodule

//--- logic/hsalign_ctrl_regs.sv
`timescale 1ns/1ps
`include "hsalign_settings.svh"

module hsalign_ctrl_regs import hsalign_pkg::*; (
    input  logic        sysclk_i,
    input  logic        wb_rst_i,
    input  bus_req_t    req_i,
    input  logic        commit_i,
    input  logic        surf_live_i,
    input  logic        surf_autotrain_en_i,
    output ctrl_state_t ctrl_o
);

    ctrl_state_t                   ctrl_q;
    logic [`HSA_AUTOTRAIN_DLY-1:0] train_dly_q;
    logic                          live_q;
    logic                          ctrl_wr;
    logic                          live_fall;
    logic                          train_release;

    // either control address hits the shared bits
    assign ctrl_wr = commit_i && req_i.we &&
                     (req_i.adr == REG_COUT_CTRL || req_i.adr == REG_DOUT_CTRL);

    // link went away, put the OSERDES back in reset
    assign live_fall = live_q && !surf_live_i;

    // autotrain as seen at the end of the delay line
    assign train_release = train_dly_q[`HSA_AUTOTRAIN_DLY-1];

    ////////////////////////////////////////
    // control bits
    ////////////////////////////////////////
    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            ctrl_q      <= ctrl_state_t'(`HSA_CTRL_RST_VALUE);
            train_dly_q <= '0;
            live_q      <= 1'b0;
        end else begin
            live_q      <= surf_live_i;
            train_dly_q <= {train_dly_q[`HSA_AUTOTRAIN_DLY-2:0], surf_autotrain_en_i};
            if (ctrl_wr) begin
                // byte 0 carries the resets and the capture phase
                if (req_i.sel[0]) begin
                    ctrl_q.iserdes_rst <= req_i.dat[2];
                    ctrl_q.oserdes_rst <= req_i.dat[4];
                    ctrl_q.dout_phase  <= req_i.dat[7];
                end
                // byte 1 carries training and the per-channel enable
                if (req_i.sel[1]) begin
                    ctrl_q.cin_train <= req_i.dat[10];
                    if (req_i.adr == REG_DOUT_CTRL)
                        ctrl_q.dout_en <= req_i.dat[8];
                    else
                        ctrl_q.cout_en <= req_i.dat[8];
                end
            end else begin
                // live drop wins over the autotrain release
                if (live_fall)
                    ctrl_q.oserdes_rst <= 1'b1;
                else if (train_release)
                    ctrl_q.oserdes_rst <= 1'b0;
                // autotrain turns training on right away
                if (surf_autotrain_en_i)
                    ctrl_q.cin_train <= 1'b1;
            end
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

//--- logic/hsalign_pkg.sv
`include "hsalign_settings.svh"

package hsalign_pkg;

    typedef logic [`HSA_DAT_W-1:0] word_t;
    typedef logic [`HSA_INTERVAL_W-1:0] interval_t;
    typedef logic [`HSA_COUNT_W-1:0] count_t;

    // register map, COUT channel at 0x00 and DOUT channel at 0x10
    typedef enum logic [`HSA_ADR_W-1:0] {
        REG_COUT_CTRL   = 6'h00,
        REG_COUT_IDELAY = 6'h04,
        REG_COUT_COUNT  = 6'h08,
        REG_COUT_DATA   = 6'h0C,
        REG_DOUT_CTRL   = 6'h10,
        REG_DOUT_IDELAY = 6'h14,
        REG_DOUT_COUNT  = 6'h18,
        REG_DOUT_DATA   = 6'h1C
    } hsalign_reg_e;

    typedef enum logic [1:0] {
        IDLE,
        TASK,
        ACK
    } bus_state_e;

    // last accepted bus request, 43 bits
    typedef struct packed {
        logic [`HSA_ADR_W-1:0] adr;
        logic                  we;
        logic [`HSA_SEL_W-1:0] sel;
        word_t                 dat;
    } bus_req_t;

    // control word layout
    // bit 2   iserdes_rst (shared)
    // bit 4   oserdes_rst (shared)
    // bit 7   dout_phase, reads 0 on COUT
    // bit 8/9 enable of the addressed channel, both copies
    // bit 10  cin_train (shared)
    // everything else reads 0
    typedef struct packed {
        logic iserdes_rst;
        logic oserdes_rst;
        logic cin_train;
        logic cout_en;
        logic dout_en;
        logic dout_phase;
    } ctrl_state_t;

endpackage

//--- logic/hsalign_settings.svh
`ifndef HSALIGN_SETTINGS_SVH
`define HSALIGN_SETTINGS_SVH

// bus geometry
`define HSA_ADR_W 6
`define HSA_DAT_W 32
`define HSA_SEL_W 4

// alignment datapath widths
`define HSA_IDELAY_W 6
`define HSA_INTERVAL_W 24
`define HSA_COUNT_W 25

// cycles from autotrain rising to the OSERDES reset release
`define HSA_AUTOTRAIN_DLY 16

// control bits after reset, in ctrl_state_t field order (only oserdes_rst set)
`define HSA_CTRL_RST_VALUE 6'b01_0000

`endif

//--- logic/hsalign_top.sv
`timescale 1ns/1ps
`include "hsalign_settings.svh"

module hsalign_top import hsalign_pkg::*; (
    input  logic                     sysclk_i,
    input  logic                     wb_rst_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [`HSA_ADR_W-1:0]    wb_adr_i,
    input  logic [`HSA_SEL_W-1:0]    wb_sel_i,
    input  logic [`HSA_DAT_W-1:0]    wb_dat_i,
    output logic                     wb_ack_o,
    output logic [`HSA_DAT_W-1:0]    wb_dat_o,
    input  logic                     surf_live_i,
    input  logic                     surf_autotrain_en_i,
    output logic                     idelay_cout_load_o,
    output logic                     idelay_dout_load_o,
    output logic [`HSA_IDELAY_W-1:0] idelay_value_o,
    input  logic [`HSA_IDELAY_W-1:0] idelay_cout_current_i,
    input  logic [`HSA_IDELAY_W-1:0] idelay_dout_current_i,
    output logic                     iserdes_cout_bitslip_o,
    output logic                     iserdes_dout_bitslip_o,
    input  logic [31:0]              cout_data_i,
    input  logic [7:0]               dout_data_i,
    output logic                     cout_capture_o,
    output logic                     dout_capture_o,
    output logic                     cout_captured_o,
    input  logic                     cout_biterr_i,
    input  logic                     dout_biterr_i,
    output logic                     iserdes_rst_o,
    output logic                     oserdes_rst_o,
    output logic                     cout_enable_o,
    output logic                     dout_enable_o,
    output logic                     dout_capture_phase_o,
    output logic                     cin_train_o,
    output logic                     mask_o
);

    bus_req_t    req;
    ctrl_state_t ctrl;
    count_t      count;
    logic        task_pulse;
    logic        commit_pulse;

    hsalign_bus_port u_bus_port (
        .sysclk_i              (sysclk_i),
        .wb_rst_i              (wb_rst_i),
        .wb_cyc_i              (wb_cyc_i),
        .wb_stb_i              (wb_stb_i),
        .wb_we_i               (wb_we_i),
        .wb_adr_i              (wb_adr_i),
        .wb_sel_i              (wb_sel_i),
        .wb_dat_i              (wb_dat_i),
        .ctrl_i                (ctrl),
        .idelay_cout_current_i (idelay_cout_current_i),
        .idelay_dout_current_i (idelay_dout_current_i),
        .cout_data_i           (cout_data_i),
        .dout_data_i           (dout_data_i),
        .count_i               (count),
        .wb_ack_o              (wb_ack_o),
        .wb_dat_o              (wb_dat_o),
        .req_o                 (req),
        .task_o                (task_pulse),
        .commit_o              (commit_pulse)
    );

    hsalign_ctrl_regs u_ctrl_regs (
        .sysclk_i            (sysclk_i),
        .wb_rst_i            (wb_rst_i),
        .req_i               (req),
        .commit_i            (commit_pulse),
        .surf_live_i         (surf_live_i),
        .surf_autotrain_en_i (surf_autotrain_en_i),
        .ctrl_o              (ctrl)
    );

    hsalign_align_engine u_align_engine (
        .sysclk_i               (sysclk_i),
        .wb_rst_i               (wb_rst_i),
        .req_i                  (req),
        .task_i                 (task_pulse),
        .commit_i               (commit_pulse),
        .cout_biterr_i          (cout_biterr_i),
        .dout_biterr_i          (dout_biterr_i),
        .idelay_cout_load_o     (idelay_cout_load_o),
        .idelay_dout_load_o     (idelay_dout_load_o),
        .idelay_value_o         (idelay_value_o),
        .iserdes_cout_bitslip_o (iserdes_cout_bitslip_o),
        .iserdes_dout_bitslip_o (iserdes_dout_bitslip_o),
        .cout_capture_o         (cout_capture_o),
        .dout_capture_o         (dout_capture_o),
        .cout_captured_o        (cout_captured_o),
        .count_o                (count)
    );

    // control bits out to the link
    assign iserdes_rst_o        = ctrl.iserdes_rst;
    assign oserdes_rst_o        = ctrl.oserdes_rst;
    assign cout_enable_o        = ctrl.cout_en;
    assign dout_enable_o        = ctrl.dout_en;
    assign dout_capture_phase_o = ctrl.dout_phase;
    assign cin_train_o          = ctrl.cin_train;
    // events masked until DOUT is enabled
    assign mask_o               = !ctrl.dout_en;

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hsalign_tb -f filelist.f

result=$(./obj_dir/Vhsalign_tb 2>&1) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'NO ERRORS'; then
    exit 0
fi
echo "simulation failed"
exit 1

//--- sim/hsalign_sva.sv
`timescale 1ns/1ps

module hsalign_sva (
    input logic sysclk_i,
    input logic wb_rst_i,
    input logic ack_i,
    input logic idelay_cout_load_i,
    input logic idelay_dout_load_i,
    input logic cout_bitslip_i,
    input logic dout_bitslip_i,
    input logic cout_capture_i,
    input logic dout_capture_i,
    input logic captured_i
);

    logic [5:0] strobes;

    // the task-cycle strobes of both channels
    assign strobes = {dout_capture_i, cout_capture_i, dout_bitslip_i,
                      cout_bitslip_i, idelay_dout_load_i, idelay_cout_load_i};

    ////////////////////////////////////////
    // bus and strobe timing
    ////////////////////////////////////////
    ack_single: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        ack_i |=> !ack_i)
        else $error("ack stayed high for two cycles");

    strobe_pulse: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        (|strobes || captured_i) |=>
            ((strobes & $past(strobes)) == '0) && !(captured_i && $past(captured_i)))
        else $error("a strobe stayed high for more than one cycle");

    strobe_onehot: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        $onehot0(strobes))
        else $error("more than one strobe high in the same cycle");

endmodule

bind hsalign_top hsalign_sva u_sva (
    .sysclk_i           (sysclk_i),
    .wb_rst_i           (wb_rst_i),
    .ack_i              (wb_ack_o),
    .idelay_cout_load_i (idelay_cout_load_o),
    .idelay_dout_load_i (idelay_dout_load_o),
    .cout_bitslip_i     (iserdes_cout_bitslip_o),
    .dout_bitslip_i     (iserdes_dout_bitslip_o),
    .cout_capture_i     (cout_capture_o),
    .dout_capture_i     (dout_capture_o),
    .captured_i         (cout_captured_o)
);

//--- sim/hsalign_tb.sv
`timescale 1ns/1ps
`include "hsalign_settings.svh"

module hsalign_tb import hsalign_pkg::*; ();

    localparam int MAX_VEC = 64;
    localparam int VEC_WORDS = 6;

    logic                     sysclk;
    logic                     wb_rst;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`HSA_ADR_W-1:0]    wb_adr;
    logic [`HSA_SEL_W-1:0]    wb_sel;
    logic [`HSA_DAT_W-1:0]    wb_dat;
    logic                     wb_ack;
    logic [`HSA_DAT_W-1:0]    wb_rdat;
    logic                     surf_live;
    logic                     surf_autotrain;
    logic                     idelay_cout_load;
    logic                     idelay_dout_load;
    logic [`HSA_IDELAY_W-1:0] idelay_value;
    logic [`HSA_IDELAY_W-1:0] idelay_cout_cur;
    logic [`HSA_IDELAY_W-1:0] idelay_dout_cur;
    logic                     cout_bitslip;
    logic                     dout_bitslip;
    logic [31:0]              cout_data;
    logic [7:0]               dout_data;
    logic                     cout_capture;
    logic                     dout_capture;
    logic                     cout_captured;
    logic                     cout_biterr;
    logic                     dout_biterr;
    logic                     iserdes_rst;
    logic                     oserdes_rst;
    logic                     cout_enable;
    logic                     dout_enable;
    logic                     dout_phase;
    logic                     cin_train;
    logic                     mask;

    // six words per vector in the order test op address select data expected
    logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS-1];
    logic [15:0] lfsr_q;
    int          cycle_count;
    int          cycle_limit;
    int          err_count;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    string       cur_name;

    hsalign_top uut (
        .sysclk_i (sysclk), .wb_rst_i (wb_rst),
        .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
        .wb_adr_i (wb_adr), .wb_sel_i (wb_sel), .wb_dat_i (wb_dat),
        .wb_ack_o (wb_ack), .wb_dat_o (wb_rdat),
        .surf_live_i (surf_live), .surf_autotrain_en_i (surf_autotrain),
        .idelay_cout_load_o (idelay_cout_load), .idelay_dout_load_o (idelay_dout_load),
        .idelay_value_o (idelay_value),
        .idelay_cout_current_i (idelay_cout_cur), .idelay_dout_current_i (idelay_dout_cur),
        .iserdes_cout_bitslip_o (cout_bitslip), .iserdes_dout_bitslip_o (dout_bitslip),
        .cout_data_i (cout_data), .dout_data_i (dout_data),
        .cout_capture_o (cout_capture), .dout_capture_o (dout_capture),
        .cout_captured_o (cout_captured),
        .cout_biterr_i (cout_biterr), .dout_biterr_i (dout_biterr),
        .iserdes_rst_o (iserdes_rst), .oserdes_rst_o (oserdes_rst),
        .cout_enable_o (cout_enable), .dout_enable_o (dout_enable),
        .dout_capture_phase_o (dout_phase), .cin_train_o (cin_train), .mask_o (mask)
    );

    ////////////////////////////////////////
    // clock and cycle limit
    ////////////////////////////////////////
    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1 shifted left
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic string test_name(logic [31:0] idx);
        case (idx)
            1: return "reset";
            2: return "ctrl_bytes";
            3: return "idelay";
            4: return "data";
            5: return "biterr";
            6: return "autotrain";
            default: return "unnamed";
        endcase
    endfunction

    // bit 0 idelay cout load up to bit 6 captured
    function automatic logic [6:0] strobe_bits();
        return {cout_captured, dout_capture, cout_capture, dout_bitslip,
                cout_bitslip, idelay_dout_load, idelay_cout_load};
    endfunction

    // bit 0 iserdes reset up to bit 6 mask
    function automatic logic [6:0] status_bits();
        return {mask, cin_train, dout_phase, dout_enable, cout_enable, oserdes_rst, iserdes_rst};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", cur_name, what, expected, actual);
            err_count++;
            test_errs++;
        end
    endtask

    ////////////////////////////////////////
    // one bus cycle, held until ack
    ////////////////////////////////////////
    task automatic bus_access(input logic we, input logic [5:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat, output logic [31:0] rdata,
                              output logic [6:0] seen);
        seen = '0;
        rdata = '0;
        @(posedge sysclk);
        #5;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_sel = sel;
        wb_dat = dat;
        do begin
            // sample mid-cycle away from the edges
            @(negedge sysclk);
            seen = seen | strobe_bits();
            if (idelay_cout_load || idelay_dout_load)
                check_value("idelay value", 32'(dat[5:0]), 32'(idelay_value));
        end while (!wb_ack);
        rdata = wb_rdat;
        @(posedge sysclk);
        #5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // drive a new random value behind the register and read it back
    task automatic read_random(input logic [5:0] adr, input logic [31:0] exp_strobes);
        logic [31:0] v;
        logic [31:0] rdata;
        logic [6:0]  seen;
        v = '0;
        @(posedge sysclk);
        #5;
        case (adr)
            REG_COUT_IDELAY: begin
                draw_bits(6, v);
                idelay_cout_cur = v[5:0];
            end
            REG_DOUT_IDELAY: begin
                draw_bits(6, v);
                idelay_dout_cur = v[5:0];
            end
            REG_COUT_DATA: begin
                draw_bits(32, v);
                cout_data = v;
            end
            REG_DOUT_DATA: begin
                draw_bits(8, v);
                dout_data = v[7:0];
            end
            default: begin
                $display("vector reads address %h, which has no random input", adr);
                err_count++;
                test_errs++;
            end
        endcase
        bus_access(1'b0, adr, 4'hf, 32'h0, rdata, seen);
        check_value($sformatf("random read %h", adr), v, rdata);
        check_value($sformatf("strobes of read %h", adr), exp_strobes, 32'(seen));
    endtask

    task automatic finish_test(input logic [31:0] idx);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s passed", idx, test_name(idx));
        end else begin
            $display("test %0d %s failed with %0d mismatches", idx, test_name(idx), test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    ////////////////////////////////////////
    // vector player
    ////////////////////////////////////////
    initial begin
        int          n_vec;
        int          wait_sum;
        int          base;
        logic [31:0] cur_test;
        logic [31:0] rdata;
        logic [6:0]  seen;
        wb_rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_sel = '0;
        wb_dat = '0;
        surf_live = 1'b1;
        surf_autotrain = 1'b0;
        idelay_cout_cur = '0;
        idelay_dout_cur = '0;
        cout_data = '0;
        dout_data = '0;
        cout_biterr = 1'b0;
        dout_biterr = 1'b0;
        lfsr_q = 16'd40;
        cycle_count = 0;
        err_count = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        $readmemh("sim/hsalign_vectors.mem", vec_mem);
        // count vectors up to the end marker and sum the waits for the limit
        n_vec = 0;
        wait_sum = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_WORDS+1] == vec_mem[n_vec*VEC_WORDS+1]
               && vec_mem[n_vec*VEC_WORDS+1] != 32'hf) begin
            if (vec_mem[n_vec*VEC_WORDS+1] == 32'h0) wait_sum += vec_mem[n_vec*VEC_WORDS+4];
            n_vec++;
        end
        cycle_limit = n_vec * 8 + wait_sum + 100;
        repeat (8) @(posedge sysclk);
        #5;
        wb_rst = 1'b0;
        cur_test = vec_mem[0];
        for (int v = 0; v < n_vec; v++) begin
            base = v * VEC_WORDS;
            if (vec_mem[base] != cur_test) begin
                finish_test(cur_test);
                cur_test = vec_mem[base];
            end
            cur_name = test_name(cur_test);
            case (vec_mem[base+1])
                0: repeat (vec_mem[base+4]) @(posedge sysclk);
                1: begin
                    bus_access(1'b1, vec_mem[base+2][5:0], vec_mem[base+3][3:0],
                               vec_mem[base+4], rdata, seen);
                    check_value($sformatf("strobes of write %h", vec_mem[base+2][5:0]),
                                vec_mem[base+5], 32'(seen));
                end
                2: begin
                    bus_access(1'b0, vec_mem[base+2][5:0], vec_mem[base+3][3:0],
                               32'h0, rdata, seen);
                    check_value($sformatf("read %h", vec_mem[base+2][5:0]),
                                vec_mem[base+5], rdata);
                end
                3: read_random(vec_mem[base+2][5:0], vec_mem[base+5]);
                4: begin
                    // data bit 0 cout biterr, 1 dout biterr, 2 live, 3 autotrain
                    @(posedge sysclk);
                    #5;
                    cout_biterr = vec_mem[base+4][0];
                    dout_biterr = vec_mem[base+4][1];
                    surf_live = vec_mem[base+4][2];
                    surf_autotrain = vec_mem[base+4][3];
                end
                5: begin
                    @(negedge sysclk);
                    check_value("status outputs", vec_mem[base+5], 32'(status_bits()));
                end
                default: begin
                    $display("vector %0d has an unknown operation code %h", v, vec_mem[base+1]);
                    err_count++;
                    test_errs++;
                end
            endcase
        end
        finish_test(cur_test);
        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim/hsalign_vectors.mem
// test op adr sel data expected, one hex word each
// op 0 wait data cycles, 1 write (expected strobes), 2 read, 3 random read (expected strobes),
// op 4 set inputs, 5 status outputs, f end
1 5 00 0 00000000 00000042
1 2 00 f 00000000 00000010
1 2 10 f 00000000 00000010
2 1 10 2 00000100 00000000
2 2 10 f 00000000 00000310
2 2 00 f 00000000 00000010
2 5 00 0 00000000 0000000a
2 1 00 1 ffff0094 00000000
2 2 00 f 00000000 00000014
2 2 10 f 00000000 00000394
2 5 00 0 00000000 0000001b
3 1 04 f 000000ab 00000041
3 1 14 f 00000015 00000042
3 3 04 f 00000000 00000000
3 3 14 f 00000000 00000000
4 3 0c f 00000000 00000050
4 3 1c f 00000000 00000060
4 1 0c f 00000000 00000044
4 1 1c f 00000000 00000048
5 4 00 0 00000006 00000000
5 1 18 f 00000014 00000040
5 0 00 0 00000032 00000000
5 2 18 f 00000000 00000014
5 1 08 f 00000014 00000040
5 0 00 0 00000032 00000000
5 2 08 f 00000000 00000000
5 4 00 0 00000004 00000000
6 4 00 0 0000000c 00000000
6 0 00 0 0000001e 00000000
6 2 00 f 00000000 00000404
6 4 00 0 00000004 00000000
6 0 00 0 00000014 00000000
6 4 00 0 00000000 00000000
6 0 00 0 00000002 00000000
6 2 00 f 00000000 00000414
6 5 00 0 00000000 0000003b
0 f 00 0 00000000 00000000
